/* odd_pipe_golden.txt */
# mode op ra rb rt rt_addr imm pc | exp_rt_value exp_wr_en exp_pc_next
# mode 0 waits for the result, mode 1 issues the next line on the next cycle
0 00 00112233445566778899aabbccddeeff 00000003000000000000000000000000 00000000000000000000000000000000 01 0000 00000000 0089119a22ab33bc44cd55de66ef77f8 1 00000000
0 01 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 02 0004 00000000 0112233445566778899aabbccddeeff0 1 00000000
0 01 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 03 0078 00000000 00112233445566778899aabbccddeeff 1 00000000
0 02 00112233445566778899aabbccddeeff 00000003000000000000000000000000 00000000000000000000000000000000 04 0000 00000000 33445566778899aabbccddeeff000000 1 00000000
0 02 00112233445566778899aabbccddeeff 00000010000000000000000000000000 00000000000000000000000000000000 05 0000 00000000 00000000000000000000000000000000 1 00000000
0 02 00112233445566778899aabbccddeeff 00000014000000000000000000000000 00000000000000000000000000000000 06 0000 00000000 00000000000000000000000000000000 1 00000000
0 03 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 07 0005 00000000 5566778899aabbccddeeff0000000000 1 00000000
0 03 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 08 001f 00000000 00000000000000000000000000000000 1 00000000
0 04 00112233445566778899aabbccddeeff 00000010000000000000000000000000 00000000000000000000000000000000 09 0000 00000000 2233445566778899aabbccddeeff0000 1 00000000
0 04 00112233445566778899aabbccddeeff 000000f8000000000000000000000000 00000000000000000000000000000000 0a 0000 00000000 00000000000000000000000000000000 1 00000000
0 05 00112233445566778899aabbccddeeff 00000004000000000000000000000000 00000000000000000000000000000000 0b 0000 00000000 445566778899aabbccddeeff00112233 1 00000000
0 05 00112233445566778899aabbccddeeff 0000000f000000000000000000000000 00000000000000000000000000000000 0b 0000 00000000 ff00112233445566778899aabbccddee 1 00000000
0 06 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 0c 0013 00000000 33445566778899aabbccddeeff001122 1 00000000
0 07 00112233445566778899aabbccddeeff 00000088000000000000000000000000 00000000000000000000000000000000 0d 0000 00000000 112233445566778899aabbccddeeff00 1 00000000
0 07 00112233445566778899aabbccddeeff 000000f8000000000000000000000000 00000000000000000000000000000000 0d 0000 00000000 ff00112233445566778899aabbccddee 1 00000000
0 08 f0000000000000000000000000000001 00000004000000000000000000000000 00000000000000000000000000000000 0e 0000 00000000 0000000000000000000000000000001f 1 00000000
0 09 f0000000000000000000000000000001 00000000000000000000000000000000 00000000000000000000000000000000 0f 0001 00000000 e0000000000000000000000000000003 1 00000000
0 09 f0000000000000000000000000000001 00000000000000000000000000000000 00000000000000000000000000000000 10 007a 00000000 c0000000000000000000000000000007 1 00000000
0 0a 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 11 0000 00000000 00005555000000000000000000000000 1 00000000
0 0b 00010000000100010000000000010000 00000000000000000000000000000000 00000000000000000000000000000000 12 0000 00000000 000000b2000000000000000000000000 1 00000000
0 0c 00010000000100010000000000010000 00000000000000000000000000000000 00000000000000000000000000000000 13 0000 00000000 00000004000000000000000000000000 1 00000000
0 0c 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 14 0000 00000000 0000000f000000000000000000000000 1 00000000
0 0d 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 15 0010 00001000 00000000000000000000000000000000 0 00001040
0 0d 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 16 fff0 00001000 00000000000000000000000000000000 0 00000fc0
0 0d 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 17 0008 0003fff0 00000000000000000000000000000000 0 00000010
0 0d 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 25 0010 00001002 00000000000000000000000000000000 0 00001042
0 0e 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 18 0100 00001000 00000000000000000000000000000000 0 00000400
0 0e 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 19 8000 00001000 00000000000000000000000000000000 0 00020000
0 0f 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 1a 0004 00001000 00001004000000000000000000000000 1 00001010
0 10 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 1b 0020 0003fffc 00000000000000000000000000000000 1 00000080
0 11 00000000000000000000000000000000 00000000000000000000000000000000 00000001000000000000000000000000 1c 0010 00001002 00000000000000000000000000000000 0 00001040
0 11 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 1d 0010 00001002 00000000000000000000000000000000 0 00001006
0 12 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 1e ffff 00002000 00000000000000000000000000000000 0 00001ffc
0 12 00000000000000000000000000000000 00000000000000000000000000000000 80000000000000000000000000000000 1f ffff 00002000 00000000000000000000000000000000 0 00002004
0 12 00000000000000000000000000000000 00000000000000000000000000000000 00000000ffffffffffffffffffffffff 20 0010 00002000 00000000000000000000000000000000 0 00002040
0 13 00000000000000000000000000000000 00000000000000000000000000000000 ffff0000000000000000000000000000 21 0002 00003000 00000000000000000000000000000000 0 00003004
0 13 00000000000000000000000000000000 00000000000000000000000000000000 00000100000000000000000000000000 22 0002 00003000 00000000000000000000000000000000 0 00003008
0 14 00000000000000000000000000000000 00000000000000000000000000000000 00010000000000000000000000000000 23 0003 00003000 00000000000000000000000000000000 0 0000300c
0 14 00000000000000000000000000000000 00000000000000000000000000000000 0000ffff000000000000000000000000 24 0003 00003000 00000000000000000000000000000000 0 00003004
1 00 00112233445566778899aabbccddeeff 00000003000000000000000000000000 00000000000000000000000000000000 30 0000 00000000 0089119a22ab33bc44cd55de66ef77f8 1 00000000
1 05 00112233445566778899aabbccddeeff 00000004000000000000000000000000 00000000000000000000000000000000 31 0000 00000000 445566778899aabbccddeeff00112233 1 00000000
1 0f 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 32 0004 00001000 00001004000000000000000000000000 1 00001010
1 0a 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 33 0000 00000000 00005555000000000000000000000000 1 00000000
1 03 00112233445566778899aabbccddeeff 00000000000000000000000000000000 00000000000000000000000000000000 34 0005 00000000 5566778899aabbccddeeff0000000000 1 00000000
0 09 f0000000000000000000000000000001 00000000000000000000000000000000 00000000000000000000000000000000 35 0001 00000000 e0000000000000000000000000000003 1 00000000
0 15 00112233445566778899aabbccddeeff 00112233445566778899aabbccddeeff 00112233445566778899aabbccddeeff 36 1234 00001000 00000000000000000000000000000000 0 00000000
1 0d 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 37 0010 00001000 00000000000000000000000000000000 0 00001040
1 15 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 38 0000 00001000 00000000000000000000000000000000 0 00000000
0 0e 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 39 0100 00001000 00000000000000000000000000000000 0 00000400

/* sources.f */
odd_pkg.sv
permute_unit.sv
branch_unit.sv
odd_pipe.sv
odd_pipe_properties.sv
odd_pipe_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --assert --timing -Wno-fatal
TOP       = odd_pipe_tb
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* odd_pipe_tb.sv */
`timescale 1ns/1ps

module odd_pipe_tb;
    import odd_pkg::*;

    logic   clk;
    logic   arst_n;
    logic   issue_valid;
    issue_t issue;
    word_t  pc;
    fwd_t   perm_fwd;
    fwd_t   branch_fwd;
    word_t  pc_next;
    logic   pc_valid;

    // expected results in issue order
    fwd_t  exp_perm [$];
    fwd_t  exp_branch [$];
    word_t exp_pc [$];
    // cycle in which each result is due
    int    exp_perm_at [$];
    int    exp_branch_at [$];

    int mismatches;
    int protocol_errors;
    int seed;
    int cycle;
    bit timed_out;

    odd_pipe dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .pc          (pc),
        .perm_fwd    (perm_fwd),
        .branch_fwd  (branch_fwd),
        .pc_next     (pc_next),
        .pc_valid    (pc_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic check_fwd(input fwd_t got, input fwd_t exp, input string what);
        if (got !== exp)
        begin
            mismatches++;
            $display("FAILED at %0t: %s record %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            mismatches++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_arrival(input int due, input string what);
        if (cycle != due)
        begin
            protocol_errors++;
            $display("%s result came in cycle %0d instead of cycle %0d at %0t",
                     what, cycle, due, $time);
        end
    endtask

    // outputs are registered, so they are stable at the falling edge
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (perm_fwd.valid)
            begin
                if (exp_perm.size() == 0)
                begin
                    protocol_errors++;
                    $display("unexpected permute result at %0t", $time);
                end
                else
                begin
                    check_fwd(perm_fwd, exp_perm.pop_front(), "permute");
                    compare_arrival(exp_perm_at.pop_front(), "permute");
                end
            end
            if (branch_fwd.valid)
            begin
                if (exp_branch.size() == 0)
                begin
                    protocol_errors++;
                    $display("unexpected branch result at %0t", $time);
                end
                else
                begin
                    check_fwd(branch_fwd, exp_branch.pop_front(), "branch");
                    check_pc(pc_next, exp_pc.pop_front(), "pc_next");
                    compare_arrival(exp_branch_at.pop_front(), "branch");
                end
            end
            if (branch_fwd.valid !== pc_valid)
            begin
                protocol_errors++;
                $display("pc_valid and the branch record valid bit disagree at %0t", $time);
            end
        end
    end

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while ((exp_perm.size() != 0 || exp_branch.size() != 0) && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (exp_perm.size() != 0 || exp_branch.size() != 0)
        begin
            timed_out = 1'b1;
            $display("timeout: a result did not arrive within 20 cycles at %0t", $time);
        end
    endtask

    initial
    begin
        int        fd;
        int        fields;
        int        mode;
        int        gap;
        string     line;
        logic [4:0]  op_code;
        quad_t     ra;
        quad_t     rb;
        quad_t     rt;
        reg_addr_t rt_addr;
        logic [15:0] imm_v;
        word_t     pc_in;
        quad_t     exp_rt;
        logic      exp_we;
        word_t     exp_pc_v;
        fwd_t      rec;

        mismatches = 0;
        protocol_errors = 0;
        timed_out = 1'b0;
        cycle = 0;
        seed = 32'hf1d0_27ca;
        arst_n = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        pc = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);

        // every registered field is cleared in reset
        check_fwd(perm_fwd, '0, "permute in reset");
        check_fwd(branch_fwd, '0, "branch in reset");
        check_pc(pc_next, '0, "pc_next in reset");
        if (pc_valid !== 1'b0)
        begin
            mismatches++;
            $display("FAILED at %0t: pc_valid is %b in reset, expected 0", $time, pc_valid);
        end
        arst_n = 1'b1;

        fd = $fopen("odd_pipe_golden.txt", "r");
        if (fd == 0)
        begin
            protocol_errors++;
            $display("could not open odd_pipe_golden.txt");
        end
        else
        begin
            while (!$feof(fd) && !timed_out)
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#")
                    continue;
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", mode, op_code,
                                 ra, rb, rt, rt_addr, imm_v, pc_in, exp_rt, exp_we, exp_pc_v);
                if (fields != 11)
                    continue;

                @(negedge clk);
                issue_valid = 1'b1;
                issue.op = odd_op_e'(op_code);
                issue.ra = ra;
                issue.rb = rb;
                issue.rt = rt;
                issue.rt_addr = rt_addr;
                issue.imm.i16 = imm_v;
                pc = pc_in;

                rec.valid = 1'b1;
                rec.rt_value = exp_rt;
                rec.wr_en = exp_we;
                rec.rt_addr = rt_addr;
                // codes 0 to 0c permute, 0d to 14 branch, the rest nobody
                if (op_code <= 5'h0c)
                begin
                    rec.unit_id = perm_unit_id;
                    exp_perm.push_back(rec);
                    exp_perm_at.push_back(cycle + perm_latency);
                end
                else if (op_code <= 5'h14)
                begin
                    rec.unit_id = branch_unit_id;
                    exp_branch.push_back(rec);
                    exp_pc.push_back(exp_pc_v);
                    exp_branch_at.push_back(cycle + branch_latency);
                end

                // mode 1 keeps issuing on the next cycle
                if (mode == 0)
                begin
                    @(negedge clk);
                    issue_valid = 1'b0;
                    wait_results();
                    gap = {$random(seed)} % 3;
                    for (int i = 0; i < gap; i++)
                        @(negedge clk);
                end
            end
            $fclose(fd);
        end

        @(negedge clk);
        issue_valid = 1'b0;
        wait_results();
        // idle tail so a stray valid still gets seen
        for (int i = 0; i < perm_latency + 2; i++)
            @(negedge clk);

        $display("mismatches: %0d, protocol errors: %0d, timeout: %0d",
                 mismatches, protocol_errors, timed_out);
        if (mismatches == 0 && protocol_errors == 0 && !timed_out)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* odd_pipe_properties.sv */
`timescale 1ns/1ps

module odd_pipe_properties (
    input logic            clk,
    input logic            arst_n,
    input logic            issue_valid,
    input odd_pkg::issue_t issue,
    input odd_pkg::fwd_t   perm_fwd,
    input odd_pkg::fwd_t   branch_fwd,
    input logic            pc_valid
);
    import odd_pkg::*;

    logic perm_issue;
    logic branch_issue;

    assign perm_issue = issue_valid && (issue.op inside {shlqbi, shlqbii, shlqby, shlqbyi,
        shlqbybi, rotqby, rotqbyi, rotqbybi, rotqbi, rotqbii, gbb, gbh, gb});
    assign branch_issue = issue_valid && (issue.op inside {br, bra, brsl, brasl,
        brnz, brz, brhnz, brhz});

    a_perm_latency: assert property (@(posedge clk) disable iff (!arst_n)
        perm_issue |-> ##perm_latency perm_fwd.valid)
        else $error("permute result missing at fixed latency");

    a_branch_latency: assert property (@(posedge clk) disable iff (!arst_n)
        branch_issue |-> ##branch_latency (branch_fwd.valid && pc_valid))
        else $error("branch result missing at fixed latency");

    // first edge after reset release
    a_idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> (!perm_fwd.valid && !branch_fwd.valid && !pc_valid))
        else $error("valid output high right after reset");

endmodule

bind odd_pipe odd_pipe_properties u_props (.*);

/* odd_pipe.sv */
`timescale 1ns/1ps

module odd_pipe (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            issue_valid,
    input  odd_pkg::issue_t issue,
    input  odd_pkg::word_t  pc,
    output odd_pkg::fwd_t   perm_fwd,
    output odd_pkg::fwd_t   branch_fwd,
    output odd_pkg::word_t  pc_next,
    output logic            pc_valid
);

    // each unit decodes its own ops from the shared issue record
    permute_unit u_permute (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .fwd         (perm_fwd)
    );

    branch_unit u_branch (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .pc          (pc),
        .fwd         (branch_fwd),
        .pc_next     (pc_next),
        .pc_valid    (pc_valid)
    );

endmodule

/* branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            issue_valid,
    input  odd_pkg::issue_t issue,
    input  odd_pkg::word_t  pc,
    output odd_pkg::fwd_t   fwd,
    output odd_pkg::word_t  pc_next,
    output logic            pc_valid
);
    import odd_pkg::*;

    logic  branch_op;
    logic  zero_w;
    logic  zero_h;
    logic  link_op;
    word_t offset;
    word_t link;
    word_t rel_target;
    word_t abs_target;
    word_t cond_target;
    word_t target;

    assign branch_op = issue.op inside {br, bra, brsl, brasl, brnz, brz, brhnz, brhz};
    assign link_op   = issue.op inside {brsl, brasl};

    // word offset from I16
    assign offset      = {{14{issue.imm.i16[0]}}, issue.imm.i16, 2'b00};
    assign link        = (pc + 32'd4) & ls_limit;
    assign rel_target  = (pc + offset) & ls_limit;
    assign abs_target  = offset & ls_limit;
    assign cond_target = rel_target & 32'hffff_fffc;

    assign zero_w = (issue.rt[0:31] == '0);
    assign zero_h = (issue.rt[16:31] == '0);

    always_comb
    begin
        case (issue.op)
            br, brsl:   target = rel_target;
            bra, brasl: target = abs_target;
            brnz:       target = !zero_w ? cond_target : link;
            brz:        target = zero_w ? cond_target : link;
            brhnz:      target = !zero_h ? cond_target : link;
            brhz:       target = zero_h ? cond_target : link;
            default:    target = link;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fwd      <= '0;
            pc_next  <= '0;
            pc_valid <= 1'b0;
        end
        else
        begin
            fwd.valid    <= issue_valid && branch_op;
            fwd.unit_id  <= branch_unit_id;
            fwd.rt_value <= link_op ? {link, {(quad_w - word_w){1'b0}}} : '0;
            fwd.wr_en    <= link_op;
            fwd.rt_addr  <= issue.rt_addr;
            pc_next      <= target;
            pc_valid     <= issue_valid && branch_op;
        end
    end

endmodule

/* permute_unit.sv */
`timescale 1ns/1ps

module permute_unit (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            issue_valid,
    input  odd_pkg::issue_t issue,
    output odd_pkg::fwd_t   fwd
);
    import odd_pkg::*;

    logic       perm_op;
    logic [0:4] cnt;
    logic [0:15] g_byte;
    logic [0:7]  g_half;
    logic [0:3]  g_word;
    quad_t      result;
    fwd_t       rec;
    fwd_t       stage [perm_latency];

    function automatic quad_t rot_left(input quad_t v, input int unsigned n);
        // n of zero gives v >> quad_w, which is all zeros
        return (v << n) | (v >> (quad_w - n));
    endfunction

    assign perm_op = issue.op inside {shlqbi, shlqbii, shlqby, shlqbyi, shlqbybi,
                                      rotqby, rotqbyi, rotqbybi, rotqbi, rotqbii,
                                      gbb, gbh, gb};

    // shift count select
    always_comb
    begin
        case (issue.op)
            shlqbi, rotqbi:     cnt = {2'b00, issue.rb[29:31]};
            shlqbii, rotqbii:   cnt = {2'b00, issue.imm.p.i7[4:6]};
            shlqby:             cnt = issue.rb[27:31];
            shlqbyi:            cnt = issue.imm.p.i7[2:6];
            shlqbybi, rotqbybi: cnt = issue.rb[24:28];
            rotqby:             cnt = {1'b0, issue.rb[28:31]};
            rotqbyi:            cnt = {1'b0, issue.imm.p.i7[3:6]};
            default:            cnt = '0;
        endcase
    end

    // lsb of each element
    always_comb
    begin
        for (int j = 0; j < quad_w / byte_w; j++)
            g_byte[j] = issue.ra[j * byte_w + byte_w - 1];
        for (int j = 0; j < quad_w / half_w; j++)
            g_half[j] = issue.ra[j * half_w + half_w - 1];
        for (int j = 0; j < quad_w / word_w; j++)
            g_word[j] = issue.ra[j * word_w + word_w - 1];
    end

    always_comb
    begin
        case (issue.op)
            shlqbi, shlqbii:           result = issue.ra << cnt[2:4];
            shlqby, shlqbyi, shlqbybi: result = issue.ra << (cnt * byte_w);
            rotqbi, rotqbii:           result = rot_left(issue.ra, cnt[2:4]);
            // byte rotates wrap at 16
            rotqby, rotqbyi, rotqbybi: result = rot_left(issue.ra, cnt[1:4] * byte_w);
            gbb: result = {{(word_w - 16){1'b0}}, g_byte, {(quad_w - word_w){1'b0}}};
            gbh: result = {{(word_w - 8){1'b0}}, g_half, {(quad_w - word_w){1'b0}}};
            gb:  result = {{(word_w - 4){1'b0}}, g_word, {(quad_w - word_w){1'b0}}};
            default: result = '0;
        endcase
    end

    always_comb
    begin
        rec.valid    = issue_valid && perm_op;
        rec.unit_id  = perm_unit_id;
        rec.rt_value = result;
        rec.wr_en    = 1'b1;
        rec.rt_addr  = issue.rt_addr;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < perm_latency; i++)
                stage[i] <= '0;
        end
        else
        begin
            stage[0] <= rec;
            for (int i = 1; i < perm_latency; i++)
                stage[i] <= stage[i - 1];
        end
    end

    assign fwd = stage[perm_latency - 1];

endmodule

/* odd_pkg.sv */
package odd_pkg;

    // widths
    localparam int quad_w     = 128;
    localparam int word_w     = 32;
    localparam int reg_addr_w = 7;
    localparam int imm_w      = 16;
    localparam int byte_w     = 8;
    localparam int half_w     = 16;

    // big-endian numbering, bit 0 is the msb
    typedef logic [0:quad_w-1]     quad_t;
    typedef logic [0:word_w-1]     word_t;
    typedef logic [0:reg_addr_w-1] reg_addr_t;

    // 18-bit local store
    localparam word_t ls_limit = 32'h0003_ffff;

    localparam logic [0:2] perm_unit_id   = 3'd5;
    localparam logic [0:2] branch_unit_id = 3'd7;

    localparam int perm_latency   = 4;
    localparam int branch_latency = 1;

    typedef enum logic [0:4] {
        shlqbi,
        shlqbii,
        shlqby,
        shlqbyi,
        shlqbybi,
        rotqby,
        rotqbyi,
        rotqbybi,
        rotqbi,
        rotqbii,
        gbb,
        gbh,
        gb,
        br,
        bra,
        brsl,
        brasl,
        brnz,
        brz,
        brhnz,
        brhz,
        nop_op
    } odd_op_e;

    // immediate field, I16 for branches or pad plus I7 for permutes
    typedef union packed {
        logic [0:imm_w-1] i16;
        struct packed {
            logic [0:8] pad;
            logic [0:6] i7;
        } p;
    } imm_u;

    typedef struct packed {
        odd_op_e   op;
        quad_t     ra;
        quad_t     rb;
        quad_t     rt;
        reg_addr_t rt_addr;
        imm_u      imm;
    } issue_t;

    typedef struct packed {
        logic       valid;
        logic [0:2] unit_id;
        quad_t      rt_value;
        logic       wr_en;
        reg_addr_t  rt_addr;
    } fwd_t;

endpackage
